//--- bench/div_checks.svh
`ifndef DIV_CHECKS_SVH
`define DIV_CHECKS_SVH

// Expected {HI, LO} for one request
// 64-bit arithmetic keeps the most negative dividend over -1 in range
function automatic logic [63:0] model_divide(div_op_t op, bus32_t a, bus32_t b);
    longint num;
    longint den;
    longint quo;
    longint rem;
    if (b == '0) begin
        return 64'd0;
    end
    if (op == OP_DIV) begin
        num = $signed(a);
        den = $signed(b);
    end else begin
        num = {32'd0, a};
        den = {32'd0, b};
    end
    // Quotient truncates toward zero and remainder follows the dividend
    quo = num / den;
    rem = num % den;
    return {rem[31:0], quo[31:0]};
endfunction

task automatic check_word(input string name, input bus32_t expected, input bus32_t actual);
    if (actual !== expected) begin
        $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        errors++;
    end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("ERROR %s: expected %b, actual %b", name, expected, actual);
        errors++;
    end
endtask

`endif

//--- bench/tb_div_unit.sv
`timescale 1ns/1ps

module tb_div_unit
    import pipeline_types::*;
();
    localparam int CLK_PERIOD = 4;
    localparam int N_DIRECTED = 10;
    localparam int N_RANDOM   = 40;
    localparam int N_BURST    = 12;
    localparam int N_TOTAL    = N_DIRECTED + N_RANDOM + N_BURST;

    logic    clk;
    logic    rst;
    logic    req_valid;
    div_op_t req_op;
    bus32_t  req_a;
    bus32_t  req_b;
    logic    req_ready;
    bus32_t  hi;
    bus32_t  lo;
    logic    result_valid;
    logic    busy;

    int     errors;
    int     seed;
    int     sent;
    int     received;
    logic   saw_full;
    bus32_t exp_hi_q[$];
    bus32_t exp_lo_q[$];
    string  name_q[$];

    `include "div_checks.svh"

    div_unit #(
        .FIFO_DEPTH(4)
    ) dut (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_op      (req_op),
        .req_a       (req_a),
        .req_b       (req_b),
        .req_ready   (req_ready),
        .hi          (hi),
        .lo          (lo),
        .result_valid(result_valid),
        .busy        (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // One falling edge: look at the outputs, then drop the request strobe
    task automatic step();
        string nm;
        @(negedge clk);
        if (!req_ready) begin
            saw_full = 1'b1;
        end
        if (name_q.size() > 0) begin
            check_bit("busy while a request is pending", 1'b1, busy);
        end
        if (result_valid) begin
            received++;
            if (name_q.size() == 0) begin
                $display("A result arrived with no request outstanding");
                errors++;
            end else begin
                nm = name_q.pop_front();
                check_word({nm, " hi"}, exp_hi_q.pop_front(), hi);
                check_word({nm, " lo"}, exp_lo_q.pop_front(), lo);
            end
        end
        req_valid = 1'b0;
    endtask

    task automatic send(input string name, input div_op_t op, input bus32_t a, input bus32_t b);
        logic [63:0] expected;
        while (!req_ready) begin
            step();
        end
        req_valid = 1'b1;
        req_op    = op;
        req_a     = a;
        req_b     = b;
        expected  = model_divide(op, a, b);
        exp_hi_q.push_back(expected[63:32]);
        exp_lo_q.push_back(expected[31:0]);
        name_q.push_back(name);
        sent++;
        step();
    endtask

    task automatic send_random(input string name);
        div_op_t op;
        bus32_t  a;
        bus32_t  b;
        op = div_op_t'($random(seed) & 1);
        a  = $random(seed);
        b  = $random(seed);
        // Narrow divisors give quotients of every size
        b  = b >> ($random(seed) & 31);
        if (($random(seed) & 15) == 0) begin
            b = '0;
        end
        send(name, op, a, b);
    endtask

    task automatic drain();
        while (name_q.size() > 0) begin
            step();
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_op    = OP_DIVU;
        req_a     = '0;
        req_b     = '0;
        errors    = 0;
        seed      = 32'hce07;
        sent      = 0;
        received  = 0;
        saw_full  = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        step();
        check_bit("reset req_ready", 1'b1, req_ready);
        check_bit("reset result_valid", 1'b0, result_valid);
        check_bit("reset busy", 1'b0, busy);
        check_word("reset hi", '0, hi);
        check_word("reset lo", '0, lo);

        send("div min by -1", OP_DIV, 32'h8000_0000, 32'hffff_ffff);
        send("div min by 1", OP_DIV, 32'h8000_0000, 32'h0000_0001);
        send("div pos by pos", OP_DIV, 32'd100, 32'd7);
        send("div neg by pos", OP_DIV, -32'sd100, 32'd7);
        send("div pos by neg", OP_DIV, 32'd100, -32'sd7);
        send("div neg by neg", OP_DIV, -32'sd100, -32'sd7);
        send("divu large", OP_DIVU, 32'hffff_fff0, 32'd3);
        send("divu small by large", OP_DIVU, 32'd5, 32'hffff_ffff);
        send("divu by zero", OP_DIVU, 32'h1234_5678, 32'h0);
        send("div by zero", OP_DIV, 32'h8765_4321, 32'h0);
        drain();

        repeat (N_RANDOM) begin
            send_random("random");
            repeat ($random(seed) & 3) step();
        end
        drain();

        saw_full = 1'b0;
        repeat (N_BURST) send_random("burst");
        drain();
        if (!saw_full) begin
            $display("The burst never filled the request queue, req_ready stayed high");
            errors++;
        end

        $display("Requests %0d, results %0d, errors %0d", sent, received, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Roughly 39 cycles per divide, so 40 per request plus a margin
    initial begin
        #((N_TOTAL * 40 + 200) * CLK_PERIOD);
        $display("Timed out with %0d of %0d results never arrived", name_q.size(), sent);
        $display("Requests %0d, results %0d, errors %0d", sent, received, errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- tb.f
+incdir+bench
verilog/pipeline_types.sv
verilog/div_req_fifo.sv
verilog/div_issue.sv
verilog/div.sv
verilog/hilo_reg.sv
verilog/div_unit.sv
bench/tb_div_unit.sv

//--- verilog/div.sv
`timescale 1ns/1ps

module div
    import pipeline_types::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        div_start,
    input  logic        div_signed,
    input  bus32_t      div_a,
    input  bus32_t      div_b,
    output logic        div_done,
    output logic [63:0] div_result
);
    div_state_t state;

    logic [5:0]  cnt;
    bus32_t      rem;
    bus32_t      quo;
    bus32_t      divisor;
    logic [33:0] trial;

    bus32_t mag_a;
    bus32_t mag_b;
    logic   neg_quo;
    logic   neg_rem;

    // Operand magnitudes for the signed opcode
    assign mag_a = (div_signed && div_a[31]) ? (~div_a + 1'b1) : div_a;
    assign mag_b = (div_signed && div_b[31]) ? (~div_b + 1'b1) : div_b;

    assign neg_quo = div_signed && (div_a[31] ^ div_b[31]);
    assign neg_rem = div_signed && div_a[31];

    // Shifted partial remainder minus divisor
    // A set bit 33 means restore
    assign trial = {1'b0, rem, quo[31]} - {2'b00, divisor};

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= DIV_FREE;
            cnt        <= '0;
            div_done   <= 1'b0;
            div_result <= '0;
        end else begin
            case (state)
                DIV_FREE: begin
                    div_done   <= 1'b0;
                    div_result <= '0;
                    if (div_start) begin
                        cnt <= '0;
                        if (div_b == '0) begin
                            state <= DIV_BY_ZERO;
                        end else begin
                            rem     <= '0;
                            quo     <= mag_a;
                            divisor <= mag_b;
                            state   <= DIV_ON;
                        end
                    end
                end
                DIV_BY_ZERO: begin
                    rem   <= '0;
                    quo   <= '0;
                    state <= DIV_END;
                end
                DIV_ON: begin
                    if (cnt != 6'd32) begin
                        if (trial[33]) begin
                            rem <= {rem[30:0], quo[31]};
                            quo <= {quo[30:0], 1'b0};
                        end else begin
                            rem <= trial[31:0];
                            quo <= {quo[30:0], 1'b1};
                        end
                        cnt <= cnt + 1'b1;
                    end else begin
                        // Sign fix-up where the remainder follows the dividend
                        if (neg_quo) begin
                            quo <= ~quo + 1'b1;
                        end
                        if (neg_rem) begin
                            rem <= ~rem + 1'b1;
                        end
                        cnt   <= '0;
                        state <= DIV_END;
                    end
                end
                DIV_END: begin
                    div_done   <= 1'b1;
                    div_result <= {rem, quo};
                    if (!div_start) begin
                        div_done   <= 1'b0;
                        div_result <= '0;
                        state      <= DIV_FREE;
                    end
                end
                default: begin
                    state <= DIV_FREE;
                end
            endcase
        end
    end

    // Done is only ever an answer to a start held by the issuer
    assert property (@(posedge clk) disable iff (rst) $rose(div_done) |-> div_start);

    // Operands are read again at fix-up time
    assert property (@(posedge clk) disable iff (rst)
        div_start && $past(div_start) |-> $stable(div_a) && $stable(div_b)
            && $stable(div_signed));

endmodule

//--- verilog/div_issue.sv
`timescale 1ns/1ps

module div_issue
    import pipeline_types::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    fifo_empty,
    input  div_op_t fifo_op,
    input  bus32_t  fifo_a,
    input  bus32_t  fifo_b,
    input  logic    div_done,
    output logic    fifo_pop,
    output logic    div_start,
    output logic    div_signed,
    output bus32_t  div_a,
    output bus32_t  div_b,
    output logic    busy
);
    typedef enum logic [1:0] {
        ISS_IDLE,
        ISS_RUN,
        ISS_DRAIN
    } iss_state_t;

    iss_state_t state;
    div_op_t    hold_op;

    assign div_signed = (hold_op == OP_DIV);
    assign busy       = (state != ISS_IDLE) || !fifo_empty;

    // Holding registers for the request in flight
    always_ff @(posedge clk) begin
        if (state == ISS_IDLE && !fifo_empty) begin
            hold_op <= fifo_op;
            div_a   <= fifo_a;
            div_b   <= fifo_b;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ISS_IDLE;
            div_start <= 1'b0;
            fifo_pop  <= 1'b0;
        end else begin
            fifo_pop <= 1'b0;
            case (state)
                ISS_IDLE: begin
                    if (!fifo_empty) begin
                        div_start <= 1'b1;
                        fifo_pop  <= 1'b1;
                        state     <= ISS_RUN;
                    end
                end
                ISS_RUN: begin
                    if (div_done) begin
                        div_start <= 1'b0;
                        state     <= ISS_DRAIN;
                    end
                end
                ISS_DRAIN: begin
                    // Divider must see a fresh start edge
                    if (!div_done) begin
                        state <= ISS_IDLE;
                    end
                end
                default: begin
                    state <= ISS_IDLE;
                end
            endcase
        end
    end

endmodule

//--- verilog/div_req_fifo.sv
`timescale 1ns/1ps

module div_req_fifo
    import pipeline_types::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    push,
    input  logic    pop,
    input  div_op_t in_op,
    input  bus32_t  in_a,
    input  bus32_t  in_b,
    output logic    full,
    output logic    empty,
    output div_op_t out_op,
    output bus32_t  out_a,
    output bus32_t  out_b
);
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    div_op_t mem_op [FIFO_DEPTH];
    bus32_t  mem_a  [FIFO_DEPTH];
    bus32_t  mem_b  [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    logic do_push;
    logic do_pop;

    assign full  = (count == FIFO_DEPTH[PTR_W:0]);
    assign empty = (count == '0);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Head of queue falls through
    assign out_op = mem_op[rd_ptr];
    assign out_a  = mem_a[rd_ptr];
    assign out_b  = mem_b[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_op[wr_ptr] <= in_op;
            mem_a[wr_ptr]  <= in_a;
            mem_b[wr_ptr]  <= in_b;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Requests posted against a full queue are lost
    assert property (@(posedge clk) disable iff (rst) push |-> !full);

    assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

//--- verilog/div_unit.sv
`timescale 1ns/1ps

module div_unit
    import pipeline_types::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    req_valid,
    input  div_op_t req_op,
    input  bus32_t  req_a,
    input  bus32_t  req_b,
    output logic    req_ready,
    output bus32_t  hi,
    output bus32_t  lo,
    output logic    result_valid,
    output logic    busy
);
    logic    fifo_full;
    logic    fifo_empty;
    logic    fifo_pop;
    div_op_t fifo_op;
    bus32_t  fifo_a;
    bus32_t  fifo_b;

    logic        div_start;
    logic        div_signed;
    bus32_t      div_a;
    bus32_t      div_b;
    logic        div_done;
    logic [63:0] div_result;

    assign req_ready = !fifo_full;

    div_req_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (req_valid),
        .pop   (fifo_pop),
        .in_op (req_op),
        .in_a  (req_a),
        .in_b  (req_b),
        .full  (fifo_full),
        .empty (fifo_empty),
        .out_op(fifo_op),
        .out_a (fifo_a),
        .out_b (fifo_b)
    );

    div_issue u_issue (
        .clk       (clk),
        .rst       (rst),
        .fifo_empty(fifo_empty),
        .fifo_op   (fifo_op),
        .fifo_a    (fifo_a),
        .fifo_b    (fifo_b),
        .div_done  (div_done),
        .fifo_pop  (fifo_pop),
        .div_start (div_start),
        .div_signed(div_signed),
        .div_a     (div_a),
        .div_b     (div_b),
        .busy      (busy)
    );

    div u_div (
        .clk       (clk),
        .rst       (rst),
        .div_start (div_start),
        .div_signed(div_signed),
        .div_a     (div_a),
        .div_b     (div_b),
        .div_done  (div_done),
        .div_result(div_result)
    );

    hilo_reg u_hilo (
        .clk         (clk),
        .rst         (rst),
        .div_done    (div_done),
        .div_result  (div_result),
        .hi          (hi),
        .lo          (lo),
        .result_valid(result_valid)
    );

endmodule

//--- verilog/hilo_reg.sv
`timescale 1ns/1ps

module hilo_reg
    import pipeline_types::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        div_done,
    input  logic [63:0] div_result,
    output bus32_t      hi,
    output bus32_t      lo,
    output logic        result_valid
);
    logic done_q;
    logic done_rise;

    // Done stays high until start drops, capture only once
    assign done_rise = div_done && !done_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            done_q       <= 1'b0;
            hi           <= '0;
            lo           <= '0;
            result_valid <= 1'b0;
        end else begin
            done_q       <= div_done;
            result_valid <= done_rise;
            if (done_rise) begin
                hi <= div_result[63:32];
                lo <= div_result[31:0];
            end
        end
    end

endmodule

//--- verilog/pipeline_types.sv
package pipeline_types;

    // One machine word of the integer pipeline
    typedef logic [31:0] bus32_t;

    // Divide opcodes as posted by the execute stage
    typedef enum logic {
        OP_DIVU = 1'b0,
        OP_DIV  = 1'b1
    } div_op_t;

    // Divider FSM states
    typedef enum logic [1:0] {
        DIV_FREE    = 2'd0,
        DIV_BY_ZERO = 2'd1,
        DIV_ON      = 2'd2,
        DIV_END     = 2'd3
    } div_state_t;

endpackage
